/* verilog/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * Data and id widths, funct3 access sizes, misalignment exception
 * codes, the local/peripheral address split and the queue payloads
 */
package lsu_pkg;

    localparam int XLEN = 32;
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    // RISC-V funct3 access size codes
    localparam logic [2:0] FN3_B  = 3'd0;
    localparam logic [2:0] FN3_H  = 3'd1;
    localparam logic [2:0] FN3_W  = 3'd2;
    localparam logic [2:0] FN3_BU = 3'd4;
    localparam logic [2:0] FN3_HU = 3'd5;

    localparam logic [XLEN-1:0] BUS_BASE = 32'h0001_0000; // Start of Wishbone range

    localparam logic [3:0] EXC_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] EXC_STORE_MISALIGNED = 4'd6;

    //////////////////////////////////////////////////////////////////////
    // Queue payloads

    // Aligned request waiting for a sub-unit
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [2:0]      fn3;
        logic [3:0]      be;    // Store lanes
        logic [XLEN-1:0] data;  // Already shifted into its lanes
        logic            store;
        id_t             id;
    } ls_req_t;

    // Load in flight, consumed when its data returns
    typedef struct packed {
        logic [1:0] offset;     // Byte within the word
        logic [2:0] fn3;
        id_t        id;
        logic       unit;       // 0 local, 1 bus
    } load_attr_t;

endpackage

/* verilog/ls_fifo.sv */
/*
 * Synchronous FIFO with a typed payload
 * Circular buffer with fall-through head data, used for both
 * the request queue and the load attribute queue
 */
module ls_fifo #(
    parameter type DATA_T = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  DATA_T push_data,
    input  logic  pop,
    output DATA_T pop_data,
    output logic  valid,
    output logic  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign pop_data = mem[rd_ptr];  // Head is visible without a pop
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> valid);

endmodule

/* verilog/ls_issue.sv */
/*
 * Issue stage of the load/store unit
 * Computes the effective address, checks alignment, builds byte
 * enables and store lanes, queues aligned requests and reports
 * misaligned ones one cycle after acceptance
 */
module ls_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic [lsu_pkg::XLEN-1:0] req_base,
    input  logic [11:0]              req_offset,
    input  logic [2:0]               req_fn3,
    input  logic                     req_store,
    input  logic [lsu_pkg::XLEN-1:0] req_data,
    input  lsu_pkg::id_t             req_id,
    output logic                     q_push,
    output lsu_pkg::ls_req_t         q_data,
    input  logic                     q_full,
    output logic                     exc_valid,
    output logic [3:0]               exc_code,
    output logic [lsu_pkg::XLEN-1:0] exc_addr,
    output lsu_pkg::id_t             exc_id
);

    logic [lsu_pkg::XLEN-1:0] eff_addr;
    logic [3:0]               be;
    logic                     misaligned;
    logic                     accept;

    assign eff_addr = req_base + {{(lsu_pkg::XLEN-12){req_offset[11]}}, req_offset};

    //////////////////////////////////////////////////////////////////////
    // Size decode for alignment and byte enables
    always_comb begin
        be         = '0;
        misaligned = 1'b0;
        case (req_fn3)
            lsu_pkg::FN3_B, lsu_pkg::FN3_BU: be[eff_addr[1:0]] = 1'b1;
            lsu_pkg::FN3_H, lsu_pkg::FN3_HU: begin
                be         = eff_addr[1] ? 4'b1100 : 4'b0011;
                misaligned = eff_addr[0];
            end
            default: begin
                be         = 4'b1111;       // Word
                misaligned = |eff_addr[1:0];
            end
        endcase
    end

    assign req_ready = ~q_full;  // Only back-pressure source
    assign accept    = req_valid & req_ready;
    assign q_push    = accept & ~misaligned;

    assign q_data = '{
        addr:  eff_addr,
        fn3:   req_fn3,
        be:    be,
        data:  req_data << {eff_addr[1:0], 3'b000},  // Move into byte lanes
        store: req_store,
        id:    req_id
    };

    //////////////////////////////////////////////////////////////////////
    // Exception report
    always_ff @(posedge clk) begin
        if (rst)
            exc_valid <= 1'b0;
        else
            exc_valid <= accept & misaligned;
    end

    always_ff @(posedge clk) begin
        if (accept & misaligned) begin
            exc_code <= req_store ? lsu_pkg::EXC_STORE_MISALIGNED
                                  : lsu_pkg::EXC_LOAD_MISALIGNED;
            exc_addr <= eff_addr;
            exc_id   <= req_id;
        end
    end

endmodule

/* verilog/ls_dispatch.sv */
/*
 * Request dispatcher
 * Pops the request queue and sends the head request to the local
 * memory or the Wishbone unit by address. Loads record their
 * attributes, and a load that switches unit waits until every
 * earlier load has returned so results stay in order
 */
module ls_dispatch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     q_valid,
    input  lsu_pkg::ls_req_t         q_data,
    output logic                     q_pop,
    output logic                     attr_push,
    output lsu_pkg::load_attr_t      attr_data,
    input  logic                     attr_full,
    input  logic                     attr_valid,
    output logic                     lm_issue,
    output logic                     bus_issue,
    output logic [lsu_pkg::XLEN-1:0] sub_addr,
    output logic [3:0]               sub_be,
    output logic                     sub_store,
    output logic [lsu_pkg::XLEN-1:0] sub_data,
    input  logic                     lm_ready,
    input  logic                     bus_ready
);

    logic to_bus;
    logic is_load;
    logic target_ready;
    logic last_unit;        // Unit of the most recent load
    logic unit_switch;
    logic switch_hold_r;
    logic switch_hold;
    logic issue;

    assign to_bus       = (q_data.addr >= lsu_pkg::BUS_BASE);
    assign is_load      = ~q_data.store;
    assign target_ready = to_bus ? bus_ready : lm_ready;

    //////////////////////////////////////////////////////////////////////
    // Unit switch hold

    // Earlier loads still outstanding on the other unit
    assign unit_switch = q_valid & is_load & attr_valid & (to_bus != last_unit);
    assign switch_hold = unit_switch | switch_hold_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            switch_hold_r <= 1'b0;
            last_unit     <= 1'b0;
        end else begin
            switch_hold_r <= (switch_hold_r | unit_switch) & attr_valid;
            if (attr_push)
                last_unit <= to_bus;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue
    assign issue = q_valid & target_ready & ~switch_hold & (~is_load | ~attr_full);

    assign q_pop     = issue;
    assign lm_issue  = issue & ~to_bus;
    assign bus_issue = issue & to_bus;
    assign attr_push = issue & is_load;

    assign attr_data = '{
        offset: q_data.addr[1:0],
        fn3:    q_data.fn3,
        id:     q_data.id,
        unit:   to_bus
    };

    // Shared request fields, qualified by the issue strobes
    assign sub_addr  = q_data.addr;
    assign sub_be    = q_data.be;
    assign sub_store = q_data.store;
    assign sub_data  = q_data.data;

endmodule

/* verilog/local_mem_unit.sv */
/*
 * Local data memory sub-unit
 * Word array with byte-enabled writes at the issue edge and
 * load data one cycle after issue. Always ready
 */
module local_mem_unit #(
    parameter int LOCAL_WORDS = 1024
) (
    input  logic                     clk,
    input  logic                     new_request,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  logic [3:0]               be,
    input  logic                     store,
    input  logic [lsu_pkg::XLEN-1:0] data_in,
    output logic                     ready,
    output logic                     data_valid,
    output logic [lsu_pkg::XLEN-1:0] data_out
);

    localparam int IDX_W = $clog2(LOCAL_WORDS);

    logic [lsu_pkg::XLEN-1:0] mem [LOCAL_WORDS];
    logic [IDX_W-1:0]         idx;

    assign idx   = addr[IDX_W+1:2];  // Word index
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (new_request && store) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    mem[idx][i*8 +: 8] <= data_in[i*8 +: 8];
        end
        if (new_request && !store)
            data_out <= mem[idx];
        data_valid <= new_request & ~store;  // Stores give no response
    end

    local_range_only: assert property (@(posedge clk)
        new_request |-> (addr < lsu_pkg::BUS_BASE));

endmodule

/* verilog/wb_bus_unit.sv */
/*
 * Wishbone classic master sub-unit
 * One transfer at a time for the peripheral range. The request is
 * latched on issue, cyc and stb stay up until ack, and read data
 * is returned in the ack cycle
 */
module wb_bus_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     new_request,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  logic [3:0]               be,
    input  logic                     store,
    input  logic [lsu_pkg::XLEN-1:0] data_in,
    output logic                     ready,
    output logic                     data_valid,
    output logic [lsu_pkg::XLEN-1:0] data_out,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [lsu_pkg::XLEN-1:0] wb_adr,
    output logic [3:0]               wb_sel,
    output logic [lsu_pkg::XLEN-1:0] wb_dat_w,
    input  logic [lsu_pkg::XLEN-1:0] wb_dat_r,
    input  logic                     wb_ack
);

    typedef enum logic {IDLE, BUSY} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else if (state == IDLE && new_request)
            state <= BUSY;
        else if (state == BUSY && wb_ack)
            state <= IDLE;  // Drop cyc/stb after ack
    end

    // Request held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (new_request) begin
            wb_adr   <= {addr[lsu_pkg::XLEN-1:2], 2'b00};
            wb_sel   <= be;
            wb_we    <= store;
            wb_dat_w <= data_in;
        end
    end

    assign wb_cyc = (state == BUSY);
    assign wb_stb = (state == BUSY);
    assign ready  = (state == IDLE);

    assign data_valid = wb_cyc & wb_ack & ~wb_we;  // Read data only
    assign data_out   = wb_dat_r;

    cyc_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)));

endmodule

/* verilog/load_align.sv */
/*
 * Load result alignment
 * Picks the returning unit's data by the head load attribute,
 * selects the byte or halfword lane and extends it
 */
module load_align (
    input  logic                     attr_valid,
    input  lsu_pkg::load_attr_t      attr_data,
    output logic                     attr_pop,
    input  logic                     lm_valid,
    input  logic [lsu_pkg::XLEN-1:0] lm_data,
    input  logic                     bus_valid,
    input  logic [lsu_pkg::XLEN-1:0] bus_data,
    output logic                     resp_valid,
    output logic [lsu_pkg::XLEN-1:0] resp_data,
    output lsu_pkg::id_t             resp_id
);

    logic [lsu_pkg::XLEN-1:0] unit_data;
    logic [lsu_pkg::XLEN-1:0] shifted;

    assign unit_data = attr_data.unit ? bus_data : lm_data;
    assign shifted   = unit_data >> {attr_data.offset, 3'b000};  // Lane to bit 0

    always_comb begin
        case (attr_data.fn3)
            lsu_pkg::FN3_B:  resp_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::FN3_BU: resp_data = {24'b0, shifted[7:0]};
            lsu_pkg::FN3_H:  resp_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::FN3_HU: resp_data = {16'b0, shifted[15:0]};
            default:         resp_data = unit_data;
        endcase
    end

    assign resp_valid = lm_valid | bus_valid;  // Only one unit returns at a time
    assign resp_id    = attr_data.id;
    assign attr_pop   = resp_valid;

    // Returning data must belong to the unit of the oldest load
    always_comb begin
        head_matches_return: assert final (!resp_valid ||
            (attr_valid && (attr_data.unit ? bus_valid && !lm_valid : lm_valid && !bus_valid)));
    end

endmodule

/* verilog/load_store_unit.sv */
/*
 * Load/store unit top level
 * Issue stage, request queue, dispatcher, local memory, Wishbone
 * master, load attribute queue and load alignment
 */
module load_store_unit #(
    parameter int LOCAL_WORDS = 1024,
    parameter int REQ_DEPTH   = 4,
    parameter int ATTR_DEPTH  = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic [lsu_pkg::XLEN-1:0] req_base,
    input  logic [11:0]              req_offset,
    input  logic [2:0]               req_fn3,
    input  logic                     req_store,
    input  logic [lsu_pkg::XLEN-1:0] req_data,
    input  lsu_pkg::id_t             req_id,
    output logic                     exc_valid,
    output logic [3:0]               exc_code,
    output logic [lsu_pkg::XLEN-1:0] exc_addr,
    output lsu_pkg::id_t             exc_id,
    output logic                     resp_valid,
    output logic [lsu_pkg::XLEN-1:0] resp_data,
    output lsu_pkg::id_t             resp_id,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [lsu_pkg::XLEN-1:0] wb_adr,
    output logic [3:0]               wb_sel,
    output logic [lsu_pkg::XLEN-1:0] wb_dat_w,
    input  logic [lsu_pkg::XLEN-1:0] wb_dat_r,
    input  logic                     wb_ack
);

    lsu_pkg::ls_req_t         q_in, q_head;
    logic                     q_push, q_pop, q_valid, q_full;
    lsu_pkg::load_attr_t      attr_in, attr_head;
    logic                     attr_push, attr_pop, attr_valid, attr_full;
    logic                     lm_issue, bus_issue, lm_ready, bus_ready;
    logic [lsu_pkg::XLEN-1:0] sub_addr, sub_data;
    logic [3:0]               sub_be;
    logic                     sub_store;
    logic                     lm_valid, bus_valid;
    logic [lsu_pkg::XLEN-1:0] lm_data, bus_data;

    ls_issue i_issue (
        .clk, .rst, .req_valid, .req_ready, .req_base, .req_offset, .req_fn3,
        .req_store, .req_data, .req_id, .q_push, .q_data(q_in), .q_full,
        .exc_valid, .exc_code, .exc_addr, .exc_id
    );

    ls_fifo #(.DATA_T(lsu_pkg::ls_req_t), .DEPTH(REQ_DEPTH)) req_queue (
        .clk, .rst, .push(q_push), .push_data(q_in), .pop(q_pop),
        .pop_data(q_head), .valid(q_valid), .full(q_full)
    );

    ls_dispatch i_dispatch (
        .clk, .rst, .q_valid, .q_data(q_head), .q_pop, .attr_push,
        .attr_data(attr_in), .attr_full, .attr_valid, .lm_issue, .bus_issue,
        .sub_addr, .sub_be, .sub_store, .sub_data, .lm_ready, .bus_ready
    );

    ls_fifo #(.DATA_T(lsu_pkg::load_attr_t), .DEPTH(ATTR_DEPTH)) attr_queue (
        .clk, .rst, .push(attr_push), .push_data(attr_in), .pop(attr_pop),
        .pop_data(attr_head), .valid(attr_valid), .full(attr_full)
    );

    local_mem_unit #(.LOCAL_WORDS(LOCAL_WORDS)) i_local_mem (
        .clk, .new_request(lm_issue), .addr(sub_addr), .be(sub_be),
        .store(sub_store), .data_in(sub_data), .ready(lm_ready),
        .data_valid(lm_valid), .data_out(lm_data)
    );

    wb_bus_unit i_wb_bus (
        .clk, .rst, .new_request(bus_issue), .addr(sub_addr), .be(sub_be),
        .store(sub_store), .data_in(sub_data), .ready(bus_ready),
        .data_valid(bus_valid), .data_out(bus_data), .wb_cyc, .wb_stb,
        .wb_we, .wb_adr, .wb_sel, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    load_align i_align (
        .attr_valid, .attr_data(attr_head), .attr_pop, .lm_valid, .lm_data,
        .bus_valid, .bus_data, .resp_valid, .resp_data, .resp_id
    );

endmodule

/* dv/wb_mem_model.sv */
/*
 * Wishbone classic slave memory model
 * Acknowledges each transfer after a random wait of 0 to 3 cycles.
 * Words never written read back a fill pattern of their address
 */
module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    logic [31:0] mem [logic [29:0]];    // Sparse, keyed by word address
    logic        started;
    int unsigned wait_left;

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        if (mem.exists(adr[31:2]))
            return mem[adr[31:2]];
        return {adr[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    always @(posedge clk) begin : respond
        logic [31:0] word;
        int unsigned wait_now;
        if (rst) begin
            wb_ack  <= 1'b0;
            started <= 1'b0;
        end else if (wb_ack) begin
            wb_ack  <= 1'b0;  // Master drops cyc in this cycle
            started <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            wait_now = started ? wait_left : $urandom_range(0, 3);
            started <= 1'b1;
            if (wait_now == 0) begin
                word = read_word(wb_adr);
                if (wb_we) begin
                    for (int i = 0; i < 4; i++)
                        if (wb_sel[i])
                            word[8*i +: 8] = wb_dat_w[8*i +: 8];
                    mem[wb_adr[31:2]] = word;
                end
                wb_dat_r <= word;
                wb_ack   <= 1'b1;
            end else begin
                wait_left <= wait_now - 1;
            end
        end
    end

endmodule

/* dv/tb_load_store_unit.sv */
/*
 * Testbench for the load/store unit
 * Applies a table of loads and stores, predicts every result from a
 * byte-wide reference memory and checks responses, exceptions and
 * Wishbone transfers in the cycle they appear
 */
module tb_load_store_unit;

    localparam int NUM_ROWS    = 38;
    localparam int WAIT_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        logic         store;
        logic [31:0]  base;
        logic [11:0]  offset;
        logic [2:0]   fn3;
        logic [31:0]  data;
        lsu_pkg::id_t id;
    } row_t;

    typedef struct packed {
        logic [31:0]  data;
        lsu_pkg::id_t id;
    } resp_t;

    typedef struct packed {
        logic [3:0]   code;
        logic [31:0]  addr;
        lsu_pkg::id_t id;
    } exc_t;

    typedef struct packed {
        logic [31:0] adr;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] dat;
    } bus_t;

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    logic [31:0]        req_base;
    logic [11:0]        req_offset;
    logic [2:0]         req_fn3;
    logic               req_store;
    logic [31:0]        req_data;
    lsu_pkg::id_t       req_id;
    logic               exc_valid;
    logic [3:0]         exc_code;
    logic [31:0]        exc_addr;
    lsu_pkg::id_t       exc_id;
    logic               resp_valid;
    logic [31:0]        resp_data;
    lsu_pkg::id_t       resp_id;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [31:0]        wb_adr;
    logic [3:0]         wb_sel;
    logic [31:0]        wb_dat_w;
    logic [31:0]        wb_dat_r;
    logic               wb_ack;

    row_t       rows [NUM_ROWS];
    logic [7:0] ref_mem [logic [31:0]];  // Byte address to contents
    resp_t      resp_q [$];
    exc_t       exc_q [$];
    bus_t       bus_q [$];

    load_store_unit #(
        .LOCAL_WORDS(1024),
        .REQ_DEPTH(4),
        .ATTR_DEPTH(2)
    ) i_dut (.*);

    wb_mem_model i_wb_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %s is %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    // Expected outcome of one accepted request
    task automatic predict(input row_t r);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] lanes;
        logic [3:0]  sel;
        int          nbytes;
        bit          misaligned;
        addr = r.base + {{20{r.offset[11]}}, r.offset};
        case (r.fn3)
            lsu_pkg::FN3_B, lsu_pkg::FN3_BU: nbytes = 1;
            lsu_pkg::FN3_H, lsu_pkg::FN3_HU: nbytes = 2;
            default:                         nbytes = 4;
        endcase
        misaligned = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
        sel = (nbytes == 1) ? 4'b0001 : (nbytes == 2) ? 4'b0011 : 4'b1111;
        sel = sel << addr[1:0];
        if (misaligned) begin
            exc_q.push_back({r.store ? lsu_pkg::EXC_STORE_MISALIGNED
                                     : lsu_pkg::EXC_LOAD_MISALIGNED, addr, r.id});
        end else begin
            if (addr >= lsu_pkg::BUS_BASE) begin
                lanes = '0;
                for (int i = 0; i < nbytes; i++)
                    lanes[8*(addr[1:0] + i) +: 8] = r.data[8*i +: 8];
                bus_q.push_back({{addr[31:2], 2'b00}, r.store, sel, lanes});
            end
            if (r.store) begin
                for (int i = 0; i < nbytes; i++)
                    ref_mem[addr + i] = r.data[8*i +: 8];
            end else begin
                word = '0;
                for (int i = 0; i < nbytes; i++) begin
                    if (!ref_mem.exists(addr + i)) begin
                        $display("load at %h reads a byte that was never written", addr);
                        abort_run();
                    end
                    word[8*i +: 8] = ref_mem[addr + i];
                end
                case (r.fn3)
                    lsu_pkg::FN3_B: word = {{24{word[7]}}, word[7:0]};
                    lsu_pkg::FN3_H: word = {{16{word[15]}}, word[15:0]};
                    default:        ;  // Upper bytes already zero
                endcase
                resp_q.push_back({word, r.id});
            end
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin : monitor
        resp_t r;
        exc_t  e;
        bus_t  b;
        if (!rst) begin
            if (resp_valid) begin
                if (resp_q.size() == 0) begin
                    $display("a load response arrived with no load outstanding");
                    abort_run();
                end else begin
                    r = resp_q.pop_front();
                    check_value("resp_id", 32'(resp_id), 32'(r.id));
                    check_value("resp_data", resp_data, r.data);
                end
            end
            if (exc_valid) begin
                if (exc_q.size() == 0) begin
                    $display("an exception was reported for a legal request");
                    abort_run();
                end else begin
                    e = exc_q.pop_front();
                    check_value("exc_id", 32'(exc_id), 32'(e.id));
                    check_value("exc_code", 32'(exc_code), 32'(e.code));
                    check_value("exc_addr", exc_addr, e.addr);
                end
            end
            if (wb_cyc)
                check_value("wb_stb", 32'(wb_stb), 32'd1);
            if (wb_cyc && wb_ack) begin
                if (bus_q.size() == 0) begin
                    $display("a Wishbone transfer happened that no request asked for");
                    abort_run();
                end else begin
                    b = bus_q.pop_front();
                    check_value("wb_adr", wb_adr, b.adr);
                    check_value("wb_we", 32'(wb_we), 32'(b.we));
                    check_value("wb_sel", 32'(wb_sel), 32'(b.sel));
                    if (b.we)
                        check_value("wb_dat_w", wb_dat_w & lane_mask(b.sel),
                                    b.dat & lane_mask(b.sel));
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus table

    function automatic row_t make_row(input logic st, input logic [31:0] base,
                                      input logic [11:0] offset, input logic [2:0] fn3,
                                      input logic [31:0] data, input logic [3:0] id);
        return {st, base, offset, fn3, data, id};
    endfunction

    task automatic fill_table();
        // Local words, then sub-word merges
        rows[0]  = make_row(1, 32'h100, 12'h000, lsu_pkg::FN3_W, 32'h1122_3344, 4'd0);
        rows[1]  = make_row(1, 32'h100, 12'h004, lsu_pkg::FN3_W, 32'h8899_aabb, 4'd1);
        rows[2]  = make_row(0, 32'h100, 12'h000, lsu_pkg::FN3_W, 32'h0, 4'd2);
        rows[3]  = make_row(1, 32'h100, 12'h001, lsu_pkg::FN3_B, 32'h0000_00e5, 4'd3);
        rows[4]  = make_row(1, 32'h100, 12'h006, lsu_pkg::FN3_H, 32'h0000_f00d, 4'd4);
        rows[5]  = make_row(0, 32'h100, 12'h000, lsu_pkg::FN3_W, 32'h0, 4'd5);
        rows[6]  = make_row(0, 32'h108, 12'hffc, lsu_pkg::FN3_W, 32'h0, 4'd6);
        // Extension at every legal offset
        rows[7]  = make_row(0, 32'h104, 12'h000, lsu_pkg::FN3_B, 32'h0, 4'd7);
        rows[8]  = make_row(0, 32'h104, 12'h001, lsu_pkg::FN3_B, 32'h0, 4'd8);
        rows[9]  = make_row(0, 32'h104, 12'h002, lsu_pkg::FN3_B, 32'h0, 4'd9);
        rows[10] = make_row(0, 32'h104, 12'h003, lsu_pkg::FN3_B, 32'h0, 4'd10);
        rows[11] = make_row(0, 32'h104, 12'h000, lsu_pkg::FN3_BU, 32'h0, 4'd11);
        rows[12] = make_row(0, 32'h104, 12'h001, lsu_pkg::FN3_BU, 32'h0, 4'd12);
        rows[13] = make_row(0, 32'h104, 12'h002, lsu_pkg::FN3_BU, 32'h0, 4'd13);
        rows[14] = make_row(0, 32'h104, 12'h003, lsu_pkg::FN3_BU, 32'h0, 4'd14);
        rows[15] = make_row(0, 32'h104, 12'h000, lsu_pkg::FN3_H, 32'h0, 4'd15);
        rows[16] = make_row(0, 32'h104, 12'h002, lsu_pkg::FN3_H, 32'h0, 4'd0);
        rows[17] = make_row(0, 32'h104, 12'h000, lsu_pkg::FN3_HU, 32'h0, 4'd1);
        rows[18] = make_row(0, 32'h104, 12'h002, lsu_pkg::FN3_HU, 32'h0, 4'd2);
        // Misaligned, then proof that memory kept its contents
        rows[19] = make_row(0, 32'h100, 12'h001, lsu_pkg::FN3_H, 32'h0, 4'd3);
        rows[20] = make_row(0, 32'h100, 12'h002, lsu_pkg::FN3_W, 32'h0, 4'd4);
        rows[21] = make_row(1, 32'h100, 12'h003, lsu_pkg::FN3_H, 32'h0000_ffff, 4'd5);
        rows[22] = make_row(1, 32'h100, 12'h001, lsu_pkg::FN3_W, 32'hdead_beef, 4'd6);
        rows[23] = make_row(0, 32'h100, 12'h000, lsu_pkg::FN3_W, 32'h0, 4'd7);
        // Peripheral range
        rows[24] = make_row(1, 32'h1_0000, 12'h000, lsu_pkg::FN3_W, 32'hcafe_0001, 4'd8);
        rows[25] = make_row(1, 32'h1_0000, 12'h004, lsu_pkg::FN3_W, 32'h5555_aaaa, 4'd9);
        rows[26] = make_row(1, 32'h1_0000, 12'h001, lsu_pkg::FN3_B, 32'h0000_0077, 4'd10);
        rows[27] = make_row(1, 32'h1_0000, 12'h006, lsu_pkg::FN3_H, 32'h0000_1234, 4'd11);
        // Loads alternating between local and bus
        rows[28] = make_row(0, 32'h1_0004, 12'hffc, lsu_pkg::FN3_W, 32'h0, 4'd12);
        rows[29] = make_row(0, 32'h100, 12'h004, lsu_pkg::FN3_W, 32'h0, 4'd13);
        rows[30] = make_row(0, 32'h1_0000, 12'h004, lsu_pkg::FN3_W, 32'h0, 4'd14);
        rows[31] = make_row(0, 32'h100, 12'h001, lsu_pkg::FN3_B, 32'h0, 4'd15);
        rows[32] = make_row(0, 32'h1_0000, 12'h002, lsu_pkg::FN3_H, 32'h0, 4'd0);
        rows[33] = make_row(0, 32'h1_0000, 12'h002, lsu_pkg::FN3_HU, 32'h0, 4'd1);
        rows[34] = make_row(1, 32'h1_0000, 12'h002, lsu_pkg::FN3_W, 32'h0bad_0bad, 4'd2);
        rows[35] = make_row(0, 32'h1_0004, 12'h003, lsu_pkg::FN3_BU, 32'h0, 4'd3);
        rows[36] = make_row(0, 32'h100, 12'h006, lsu_pkg::FN3_HU, 32'h0, 4'd4);
        rows[37] = make_row(0, 32'h1_0004, 12'h000, lsu_pkg::FN3_W, 32'h0, 4'd5);
    endtask

    // Called one time unit after a rising edge
    task automatic send_row(input row_t r);
        int waited;
        req_valid  = 1'b1;
        req_store  = r.store;
        req_base   = r.base;
        req_offset = r.offset;
        req_fn3    = r.fn3;
        req_data   = r.data;
        req_id     = r.id;
        waited     = 0;
        while (!req_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout waiting for req_ready with request id %0d", r.id);
                abort_run();
            end
        end
        predict(r);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : stimulus
        int unsigned gap;
        int          waited;
        void'($urandom(32'he5e7b1bf));
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_base   = '0;
        req_offset = '0;
        req_fn3    = '0;
        req_store  = 1'b0;
        req_data   = '0;
        req_id     = '0;
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("resp_valid", 32'(resp_valid), 32'd0);
        check_value("exc_valid", 32'(exc_valid), 32'd0);
        check_value("wb_cyc", 32'(wb_cyc), 32'd0);
        check_value("wb_stb", 32'(wb_stb), 32'd0);
        @(posedge clk);
        #1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_row(rows[r]);
            gap = $urandom_range(0, 2);  // Idle cycles between requests
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end

        waited = 0;
        while (resp_q.size() != 0 || exc_q.size() != 0 || bus_q.size() != 0 || wb_cyc) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("timeout waiting for outstanding requests to complete");
                abort_run();
            end
        end
        repeat (8) @(posedge clk);  // Catch stray responses

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sources.f */
verilog/lsu_pkg.sv
verilog/ls_fifo.sv
verilog/ls_issue.sv
verilog/ls_dispatch.sv
verilog/local_mem_unit.sv
verilog/wb_bus_unit.sv
verilog/load_align.sv
verilog/load_store_unit.sv
dv/wb_mem_model.sv
dv/tb_load_store_unit.sv

/* Makefile */
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "PASS: all tests" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
